/* Bender.yml */
package:
  name: fm_synth

sources:
  - include_dirs:
      - .
    files:
      - fm_pkg.sv
      - fm_axil_regs.sv
      - fm_channel_engine.sv
      - fm_mixer.sv
      - fm_i2s_tx.sv
      - fm_synth_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - fm_synth_assertions.sv
      - tb_fm_synth.sv

/* all.f */
+incdir+.
fm_pkg.sv
fm_axil_regs.sv
fm_channel_engine.sv
fm_mixer.sv
fm_i2s_tx.sv
fm_synth_top.sv
fm_synth_assertions.sv
tb_fm_synth.sv

/* fm_axil_regs.sv */
// one write and one read in flight at a time; the master must hold awvalid and wvalid together
`timescale 1ns/1ps
`default_nettype none

`include "fm_params.svh"

module fm_axil_regs (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic [`FM_AXI_ADDR_W-1:0]     awaddr,
    input  logic                          awvalid,
    output logic                          awready,
    input  logic [`FM_AXI_DATA_W-1:0]     wdata,
    input  logic [`FM_AXI_DATA_W/8-1:0]   wstrb,
    input  logic                          wvalid,
    output logic                          wready,
    output fm_pkg::axi_resp_t             bresp,
    output logic                          bvalid,
    input  logic                          bready,
    input  logic [`FM_AXI_ADDR_W-1:0]     araddr,
    input  logic                          arvalid,
    output logic                          arready,
    output logic [`FM_AXI_DATA_W-1:0]     rdata,
    output fm_pkg::axi_resp_t             rresp,
    output logic                          rvalid,
    input  logic                          rready,
    output logic [`FM_PHASE_W-1:0]        ch_inc  [`FM_NUM_CH],
    output fm_pkg::wave_t                 ch_wave [`FM_NUM_CH],
    output logic [`FM_ATT_W-1:0]          ch_att  [`FM_NUM_CH],
    output logic                          ch_key  [`FM_NUM_CH]
);
    localparam int IDX_W    = $clog2(`FM_NUM_CH);
    localparam int IDX_LSB  = $clog2(`FM_REG_STRIDE);      // word aligned
    localparam int MAP_SIZE = `FM_NUM_CH * `FM_REG_STRIDE;  // first unmapped byte
    localparam int WAVE_W   = $bits(fm_pkg::wave_t);

    logic [IDX_W-1:0]          aw_idx;
    logic [IDX_W-1:0]          ar_idx;
    logic                      aw_hit;
    logic                      ar_hit;
    logic                      aw_fire;
    logic                      ar_fire;
    logic [`FM_AXI_DATA_W-1:0] merged;     // current word with strobed bytes replaced
    logic [`FM_AXI_DATA_W-1:0] rd_word;

    // fields back into bus layout, unused bits zero
    function automatic logic [`FM_AXI_DATA_W-1:0] pack_reg(
        input logic [`FM_PHASE_W-1:0] inc,
        input fm_pkg::wave_t          wave,
        input logic [`FM_ATT_W-1:0]   att,
        input logic                   key
    );
        logic [`FM_AXI_DATA_W-1:0] word;
        word = '0;
        word[`FM_REG_INC_LSB +: `FM_PHASE_W] = inc;
        word[`FM_REG_WAVE_LSB +: WAVE_W]     = wave;
        word[`FM_REG_ATT_LSB +: `FM_ATT_W]   = att;
        word[`FM_REG_KEY_BIT]                = key;
        return word;
    endfunction

    always_comb begin
        aw_idx  = awaddr[IDX_LSB +: IDX_W];
        ar_idx  = araddr[IDX_LSB +: IDX_W];
        aw_hit  = awaddr < MAP_SIZE;
        ar_hit  = araddr < MAP_SIZE;
        aw_fire = awvalid && awready && wvalid && wready;
        ar_fire = arvalid && arready;
        merged  = pack_reg(ch_inc[aw_idx], ch_wave[aw_idx], ch_att[aw_idx], ch_key[aw_idx]);
        for (int b = 0; b < `FM_AXI_DATA_W / 8; b++) begin
            if (wstrb[b]) begin
                merged[8*b +: 8] = wdata[8*b +: 8];     // byte lane merge
            end
        end
        rd_word = ar_hit ? pack_reg(ch_inc[ar_idx], ch_wave[ar_idx], ch_att[ar_idx],
                                    ch_key[ar_idx]) : '0;
    end

    // handshake state
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            awready <= 1'b0;
            wready  <= 1'b0;
            bvalid  <= 1'b0;
            arready <= 1'b0;
            rvalid  <= 1'b0;
        end else begin
            awready <= awvalid && wvalid && !awready && !bvalid;   // one-cycle pulse
            wready  <= awvalid && wvalid && !awready && !bvalid;
            arready <= arvalid && !arready && !rvalid;
            if (aw_fire) begin
                bvalid <= 1'b1;
            end else if (bvalid && bready) begin
                bvalid <= 1'b0;
            end
            if (ar_fire) begin
                rvalid <= 1'b1;
            end else if (rvalid && rready) begin
                rvalid <= 1'b0;
            end
        end
    end

    // response payload, held while valid waits
    always_ff @(posedge clk) begin
        if (aw_fire) begin
            bresp <= aw_hit ? fm_pkg::OKAY : fm_pkg::SLVERR;
        end
        if (ar_fire) begin
            rdata <= rd_word;                              // zero when unmapped
            rresp <= ar_hit ? fm_pkg::OKAY : fm_pkg::SLVERR;
        end
    end

    // channel controls
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < `FM_NUM_CH; i++) begin
                ch_inc[i]  <= '0;
                ch_wave[i] <= fm_pkg::WAVE_SQUARE;
                ch_att[i]  <= '0;
                ch_key[i]  <= 1'b0;                        // all keyed off
            end
        end else if (aw_fire && aw_hit) begin
            ch_inc[aw_idx]  <= merged[`FM_REG_INC_LSB +: `FM_PHASE_W];
            ch_wave[aw_idx] <= fm_pkg::wave_t'(merged[`FM_REG_WAVE_LSB +: WAVE_W]);
            ch_att[aw_idx]  <= merged[`FM_REG_ATT_LSB +: `FM_ATT_W];
            ch_key[aw_idx]  <= merged[`FM_REG_KEY_BIT];
        end
    end

endmodule

`default_nettype wire

/* fm_channel_engine.sv */
// phase and sample widths must match; outputs update only on the clk after sample_tick
`timescale 1ns/1ps
`default_nettype none

`include "fm_params.svh"

module fm_channel_engine (
    input  logic                           clk,
    input  logic                           rst_n,
    input  logic                           sample_tick,
    input  logic [`FM_PHASE_W-1:0]         ch_inc    [`FM_NUM_CH],
    input  fm_pkg::wave_t                  ch_wave   [`FM_NUM_CH],
    input  logic [`FM_ATT_W-1:0]           ch_att    [`FM_NUM_CH],
    input  logic                           ch_key    [`FM_NUM_CH],
    output logic signed [`FM_SAMPLE_W-1:0] ch_sample [`FM_NUM_CH]
);
    localparam int PH_MSB = `FM_PHASE_W - 1;
    localparam int SW     = `FM_SAMPLE_W;

    // full-scale square levels
    localparam logic signed [SW-1:0] SQ_HIGH = {1'b0, {(SW-1){1'b1}}};     // 32767
    localparam logic signed [SW-1:0] SQ_LOW  = {1'b1, {(SW-1){1'b0}}};     // -32768

    logic [`FM_PHASE_W-1:0] phase  [`FM_NUM_CH];
    logic signed [SW-1:0]   shaped [`FM_NUM_CH];   // attenuated, keyed

    // raw waveform at full scale from one phase value
    function automatic logic signed [SW-1:0] shape(
        input logic [`FM_PHASE_W-1:0] ph,
        input fm_pkg::wave_t          wave
    );
        logic [PH_MSB-1:0]    fold;
        logic signed [SW-1:0] val;
        // second half of the cycle runs back down
        fold = ph[PH_MSB] ? ~ph[PH_MSB-1:0] : ph[PH_MSB-1:0];
        case (wave)
            fm_pkg::WAVE_SAW: begin
                val = {~ph[PH_MSB], ph[PH_MSB-1:0]};             // offset binary to signed
            end
            fm_pkg::WAVE_TRI: begin
                val = {~fold[PH_MSB-1], fold[PH_MSB-2:0], 1'b0};  // 2*fold - 32768
            end
            default: begin
                val = ph[PH_MSB] ? SQ_LOW : SQ_HIGH;             // square, and code 3
            end
        endcase
        return val;
    endfunction

    // shaping and attenuation, from the phase before this tick's step
    always_comb begin
        for (int i = 0; i < `FM_NUM_CH; i++) begin
            if (ch_key[i]) begin
                shaped[i] = shape(phase[i], ch_wave[i]) >>> ch_att[i];  // sign kept
            end else begin
                shaped[i] = '0;                           // silent when keyed off
            end
        end
    end

    // phase accumulators
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < `FM_NUM_CH; i++) begin
                phase[i] <= '0;
            end
        end else if (sample_tick) begin
            for (int i = 0; i < `FM_NUM_CH; i++) begin
                if (ch_key[i]) begin
                    phase[i] <= phase[i] + ch_inc[i];     // wraps mod 2^16
                end else begin
                    phase[i] <= '0;                       // restart point for next key-on
                end
            end
        end
    end

    // registered channel outputs
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < `FM_NUM_CH; i++) begin
                ch_sample[i] <= '0;
            end
        end else if (sample_tick) begin
            for (int i = 0; i < `FM_NUM_CH; i++) begin
                ch_sample[i] <= shaped[i];
            end
        end
    end

endmodule

`default_nettype wire

/* fm_i2s_tx.sv */
// free-running master, no back-pressure; sample width must equal the I2S slot width
`timescale 1ns/1ps
`default_nettype none

`include "fm_params.svh"

module fm_i2s_tx (
    input  logic                           clk,
    input  logic                           rst_n,
    input  logic signed [`FM_SAMPLE_W-1:0] left,
    input  logic signed [`FM_SAMPLE_W-1:0] right,
    output logic                           sample_tick,
    output logic                           i2s_sclk,
    output logic                           i2s_ws,
    output logic                           i2s_sd
);
    localparam int SCLK_CYC  = 2 * `FM_SCLK_DIV;                 // clk per sclk period
    localparam int FRAME_CYC = SCLK_CYC * 2 * `FM_I2S_BITS;      // 128 clk
    localparam int CNT_W     = $clog2(FRAME_CYC);
    localparam int SH_W      = 2 * `FM_I2S_BITS;

    logic [CNT_W-1:0] cnt;          // clk position in frame
    logic [CNT_W-1:0] cnt_nxt;
    logic             fall_nxt;     // sclk falls at this edge
    logic [SH_W-1:0]  shreg;        // left then right, MSB first

    always_comb begin
        cnt_nxt  = (cnt == CNT_W'(FRAME_CYC - 1)) ? '0 : cnt + 1'b1;
        fall_nxt = (cnt_nxt % SCLK_CYC) == 0;
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            cnt         <= '0;
            i2s_sclk    <= 1'b0;
            i2s_ws      <= 1'b0;
            i2s_sd      <= 1'b0;
            sample_tick <= 1'b0;
            shreg       <= '0;
        end else begin
            cnt         <= cnt_nxt;
            i2s_sclk    <= (cnt_nxt % SCLK_CYC) >= `FM_SCLK_DIV;   // low half first
            i2s_ws      <= (cnt_nxt / SCLK_CYC) >= `FM_I2S_BITS;   // high for right slot
            sample_tick <= cnt_nxt == '0;                          // frame start
            if (fall_nxt) begin
                // sd lags ws by one sclk, so the last right bit spills into
                // the first period of the next frame
                i2s_sd <= shreg[SH_W-1];
                if (cnt_nxt == '0) begin
                    shreg <= {left, right};         // latched ahead of the engine tick
                end else begin
                    shreg <= {shreg[SH_W-2:0], 1'b0};
                end
            end
        end
    end

endmodule

`default_nettype wire

/* fm_mixer.sv */
// fixed pairing for four channels, 0+2 left and 1+3 right; latency is two clk cycles
`timescale 1ns/1ps
`default_nettype none

`include "fm_params.svh"

module fm_mixer (
    input  logic                           clk,
    input  logic                           rst_n,
    input  logic signed [`FM_SAMPLE_W-1:0] ch_sample [`FM_NUM_CH],
    output logic signed [`FM_SAMPLE_W-1:0] left,
    output logic signed [`FM_SAMPLE_W-1:0] right
);
    localparam int SW    = `FM_SAMPLE_W;
    localparam int SUM_W = SW + 1;                  // room for one carry

    localparam logic signed [SW-1:0] SAT_MAX = {1'b0, {(SW-1){1'b1}}};
    localparam logic signed [SW-1:0] SAT_MIN = {1'b1, {(SW-1){1'b0}}};

    logic signed [SUM_W-1:0] sum_l;
    logic signed [SUM_W-1:0] sum_r;

    // clamp when the two top bits disagree
    function automatic logic signed [SW-1:0] clamp(input logic signed [SUM_W-1:0] s);
        logic signed [SW-1:0] res;
        if (s[SUM_W-1] != s[SUM_W-2]) begin
            res = s[SUM_W-1] ? SAT_MIN : SAT_MAX;
        end else begin
            res = s[SW-1:0];
        end
        return res;
    endfunction

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            sum_l <= '0;
            sum_r <= '0;
            left  <= '0;
            right <= '0;
        end else begin
            sum_l <= ch_sample[0] + ch_sample[2];   // stage 1, sign extended
            sum_r <= ch_sample[1] + ch_sample[3];
            left  <= clamp(sum_l);                  // stage 2
            right <= clamp(sum_r);
        end
    end

endmodule

`default_nettype wire

/* fm_params.svh */
// all widths are fixed for a 4-channel, 16-bit build; the sample, phase and I2S slot widths must stay equal
`ifndef FM_PARAMS_SVH
`define FM_PARAMS_SVH

// datapath widths
`define FM_NUM_CH       4       // tone channels, even ones go left
`define FM_SAMPLE_W     16      // signed sample width
`define FM_PHASE_W      16      // accumulator and increment width
`define FM_ATT_W        4       // attenuation shift amount

// host bus
`define FM_AXI_DATA_W   32
`define FM_AXI_ADDR_W   6       // byte address
`define FM_REG_STRIDE   4       // bytes per channel register

// channel register fields
`define FM_REG_INC_LSB  0       // increment, 16 bits
`define FM_REG_WAVE_LSB 16      // waveform code, 2 bits
`define FM_REG_ATT_LSB  18      // attenuation, 4 bits
`define FM_REG_KEY_BIT  24      // key-on

// I2S frame geometry
`define FM_I2S_BITS     16      // bits per slot
`define FM_SCLK_DIV     2       // clk cycles per half sclk period

`endif

/* fm_pkg.sv */
// waveform code 3 has no name and is played as a square wave by the channel engine
`default_nettype none

package fm_pkg;

    // waveform select, two bits wide in the channel register
    typedef enum logic [1:0] {
        WAVE_SQUARE = 2'd0,     // also used for code 3
        WAVE_SAW    = 2'd1,
        WAVE_TRI    = 2'd2
    } wave_t;

    // AXI4-Lite response codes, only the two this slave returns
    typedef enum logic [1:0] {
        OKAY   = 2'b00,
        SLVERR = 2'b10          // unmapped address
    } axi_resp_t;

endpackage

`default_nettype wire

/* fm_synth_assertions.sv */
// sampled on clk, idle while rst_n is low; bound into fm_synth_top and sees its internal tick
`timescale 1ns/1ps
`default_nettype none

`include "fm_params.svh"

module fm_synth_assertions (
    input logic                      clk,
    input logic                      rst_n,
    input logic                      bvalid,
    input logic                      bready,
    input logic                      rvalid,
    input logic                      rready,
    input logic [`FM_AXI_DATA_W-1:0] rdata,
    input logic                      i2s_sclk,
    input logic                      i2s_ws,
    input logic                      sample_tick
);
    int fails = 0;      // failed property count

    b_hold: assert property (@(posedge clk) disable iff (!rst_n) bvalid && !bready |=> bvalid)
    else begin
        fails++;
        $error("bvalid dropped before bready");
    end

    r_hold: assert property (@(posedge clk) disable iff (!rst_n)
                             rvalid && !rready |=> rvalid && $stable(rdata))
    else begin
        fails++;
        $error("rvalid or rdata changed before rready");
    end

    // ws moves with the sclk falling edge only
    ws_edge: assert property (@(posedge clk) disable iff (!rst_n)
                              $changed(i2s_ws) |-> $fell(i2s_sclk))
    else begin
        fails++;
        $error("ws changed away from a falling sclk");
    end

    tick_len: assert property (@(posedge clk) disable iff (!rst_n) sample_tick |=> !sample_tick)
    else begin
        fails++;
        $error("sample_tick held longer than one cycle");
    end

endmodule

`default_nettype wire

/* fm_synth_top.sv */
// clk comes straight from the board and rst_n is the only reset; one I2S frame per stereo sample
`timescale 1ns/1ps
`default_nettype none

`include "fm_params.svh"

module fm_synth_top (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic [`FM_AXI_ADDR_W-1:0]   awaddr,
    input  logic                        awvalid,
    output logic                        awready,
    input  logic [`FM_AXI_DATA_W-1:0]   wdata,
    input  logic [`FM_AXI_DATA_W/8-1:0] wstrb,
    input  logic                        wvalid,
    output logic                        wready,
    output fm_pkg::axi_resp_t           bresp,
    output logic                        bvalid,
    input  logic                        bready,
    input  logic [`FM_AXI_ADDR_W-1:0]   araddr,
    input  logic                        arvalid,
    output logic                        arready,
    output logic [`FM_AXI_DATA_W-1:0]   rdata,
    output fm_pkg::axi_resp_t           rresp,
    output logic                        rvalid,
    input  logic                        rready,
    output logic                        i2s_sclk,
    output logic                        i2s_ws,
    output logic                        i2s_sd
);
    logic [`FM_PHASE_W-1:0]         ch_inc    [`FM_NUM_CH];
    fm_pkg::wave_t                  ch_wave   [`FM_NUM_CH];
    logic [`FM_ATT_W-1:0]           ch_att    [`FM_NUM_CH];
    logic                           ch_key    [`FM_NUM_CH];
    logic signed [`FM_SAMPLE_W-1:0] ch_sample [`FM_NUM_CH];
    logic signed [`FM_SAMPLE_W-1:0] mix_l;
    logic signed [`FM_SAMPLE_W-1:0] mix_r;
    logic                           sample_tick;    // from the I2S frame start

    fm_axil_regs u_regs (
        .clk     (clk),
        .rst_n   (rst_n),
        .awaddr  (awaddr),
        .awvalid (awvalid),
        .awready (awready),
        .wdata   (wdata),
        .wstrb   (wstrb),
        .wvalid  (wvalid),
        .wready  (wready),
        .bresp   (bresp),
        .bvalid  (bvalid),
        .bready  (bready),
        .araddr  (araddr),
        .arvalid (arvalid),
        .arready (arready),
        .rdata   (rdata),
        .rresp   (rresp),
        .rvalid  (rvalid),
        .rready  (rready),
        .ch_inc  (ch_inc),
        .ch_wave (ch_wave),
        .ch_att  (ch_att),
        .ch_key  (ch_key)
    );

    fm_channel_engine u_engine (
        .clk         (clk),
        .rst_n       (rst_n),
        .sample_tick (sample_tick),
        .ch_inc      (ch_inc),
        .ch_wave     (ch_wave),
        .ch_att      (ch_att),
        .ch_key      (ch_key),
        .ch_sample   (ch_sample)
    );

    fm_mixer u_mixer (
        .clk       (clk),
        .rst_n     (rst_n),
        .ch_sample (ch_sample),
        .left      (mix_l),
        .right     (mix_r)
    );

    fm_i2s_tx u_i2s (
        .clk         (clk),
        .rst_n       (rst_n),
        .left        (mix_l),
        .right       (mix_r),
        .sample_tick (sample_tick),
        .i2s_sclk    (i2s_sclk),
        .i2s_ws      (i2s_ws),
        .i2s_sd      (i2s_sd)
    );

endmodule

`default_nettype wire

/* tb_fm_synth.sv */
// assumes FM_SCLK_DIV 2 and 16-bit slots; channel 0 is the only left source in the stepping tests
`timescale 1ns/1ps
`default_nettype none

`include "fm_params.svh"

module tb_fm_synth;
    localparam int          WAIT_AXI = 64;             // clk cycles per handshake phase
    localparam int          NFR      = 14;             // frames kept per stepping run
    localparam int          STALL    = 2;              // cycles bready and rready stay low
    localparam logic [31:0] REG_MASK = 32'h013f_ffff;  // key, att, wave, inc bits

    logic                        clk = 1'b0;
    logic                        rst_n;
    logic [`FM_AXI_ADDR_W-1:0]   awaddr;
    logic [`FM_AXI_ADDR_W-1:0]   araddr;
    logic [`FM_AXI_DATA_W-1:0]   wdata;
    logic [`FM_AXI_DATA_W-1:0]   rdata;
    logic [`FM_AXI_DATA_W/8-1:0] wstrb;
    logic                        awvalid;
    logic                        awready;
    logic                        wvalid;
    logic                        wready;
    logic                        bvalid;
    logic                        bready;
    logic                        arvalid;
    logic                        arready;
    logic                        rvalid;
    logic                        rready;
    fm_pkg::axi_resp_t           bresp;
    fm_pkg::axi_resp_t           rresp;
    logic                        i2s_sclk;
    logic                        i2s_ws;
    logic                        i2s_sd;

    integer      seed = 32'hebd8814c;
    int          checks = 0;
    int          errors = 0;
    int          test_errors = 0;
    bit          hung = 1'b0;            // set once any wait runs out
    logic [31:0] frames [$];             // {left, right} per decoded frame
    logic [15:0] fl [NFR];
    logic [15:0] fr [NFR];
    logic [15:0] shift_word = '0;
    logic [15:0] left_word = '0;
    logic        last_ws = 1'b0;
    logic [31:0] model [`FM_NUM_CH];     // expected register contents

    always #50 clk = ~clk;

    fm_synth_top dut (.*);

    bind fm_synth_top fm_synth_assertions u_assert (
        .clk         (clk),
        .rst_n       (rst_n),
        .bvalid      (bvalid),
        .bready      (bready),
        .rvalid      (rvalid),
        .rready      (rready),
        .rdata       (rdata),
        .i2s_sclk    (i2s_sclk),
        .i2s_ws      (i2s_ws),
        .sample_tick (sample_tick)
    );

    // I2S decoder; a ws edge means the bit just taken closes the previous slot
    always @(posedge i2s_sclk) begin
        if (rst_n) begin
            shift_word = {shift_word[14:0], i2s_sd};
            if (i2s_ws != last_ws) begin
                if (last_ws) begin
                    frames.push_back({left_word, shift_word});  // right slot done
                end else begin
                    left_word = shift_word;
                end
            end
            last_ws = i2s_ws;
        end
    end

    // expected channel output straight from the waveform rules
    function automatic logic [15:0] ref_sample(input logic [15:0] ph, input logic [1:0] wave,
                                               input logic [3:0] att, input logic key);
        int v;
        int fold;
        fold = ph[14:0];
        case (wave)
            2'd1: v = int'(ph) - 32768;                // saw is the phase with its top bit flipped
            2'd2: begin
                if (ph[15]) fold = 32767 - fold;       // falling half
                v = 2 * fold - 32768;
            end
            default: v = ph[15] ? -32768 : 32767;
        endcase
        v = v >>> att;
        return key ? v[15:0] : 16'h0;
    endfunction

    function automatic logic [15:0] sat_sum(input logic [15:0] a, input logic [15:0] b);
        int s;
        s = int'($signed(a)) + int'($signed(b));
        if (s > 32767) s = 32767;
        if (s < -32768) s = -32768;
        return s[15:0];
    endfunction

    task automatic check(input string name, input logic [31:0] act, input logic [31:0] exp);
        if (!hung) begin
            checks++;
            if (act !== exp) begin
                $display("Error: %s is 0x%0h, expected 0x%0h", name, act, exp);
                errors++;
                test_errors++;
            end
        end
    endtask

    task automatic note_failure(input string msg);
        $display("%s", msg);
        errors++;
        test_errors++;
    endtask

    task automatic finish_test(input string name);
        $display("test %-10s done, %0d mismatches", name, test_errors);
        test_errors = 0;
    endtask

    task automatic axi_write(input logic [5:0] addr, input logic [31:0] data,
                             input logic [3:0] strb, output logic [1:0] resp);
        bit got;
        resp = 2'b11;
        got  = 1'b0;
        if (!hung) begin
            @(negedge clk);
            awaddr  = addr;
            wdata   = data;
            wstrb   = strb;
            awvalid = 1'b1;
            wvalid  = 1'b1;
            for (int n = 0; n < WAIT_AXI && !got; n++) begin
                @(negedge clk);
                got = awready && wready;            // accepted on the next rising edge
            end
            if (!got) begin
                note_failure("timeout: write address and data never accepted");
                hung = 1'b1;
            end
            got = 1'b0;
            for (int n = 0; n < WAIT_AXI && !got && !hung; n++) begin
                @(negedge clk);
                awvalid = 1'b0;
                wvalid  = 1'b0;
                if (bvalid) begin
                    resp = bresp;
                    got  = 1'b1;
                end
            end
            if (!got && !hung) begin
                note_failure("timeout: no write response");
                hung = 1'b1;
            end
            if (got) begin
                repeat (STALL) @(negedge clk);      // response held under back-pressure
                check("bvalid", bvalid, 1'b1);
                bready = 1'b1;
                @(negedge clk);
                bready = 1'b0;
            end
        end
    endtask

    task automatic axi_read(input logic [5:0] addr, output logic [31:0] data,
                            output logic [1:0] resp);
        bit got;
        data = 'x;
        resp = 2'b11;
        got  = 1'b0;
        if (!hung) begin
            @(negedge clk);
            araddr  = addr;
            arvalid = 1'b1;
            for (int n = 0; n < WAIT_AXI && !got; n++) begin
                @(negedge clk);
                got = arready;
            end
            if (!got) begin
                note_failure("timeout: read address never accepted");
                hung = 1'b1;
            end
            got = 1'b0;
            for (int n = 0; n < WAIT_AXI && !got && !hung; n++) begin
                @(negedge clk);
                arvalid = 1'b0;
                if (rvalid) begin
                    data = rdata;
                    resp = rresp;
                    got  = 1'b1;
                end
            end
            if (!got && !hung) begin
                note_failure("timeout: no read data");
                hung = 1'b1;
            end
            if (got) begin
                repeat (STALL) @(negedge clk);      // data held under back-pressure
                check("rvalid", rvalid, 1'b1);
                check("rdata", rdata, data);
                rready = 1'b1;
                @(negedge clk);
                rready = 1'b0;
            end
        end
    endtask

    task automatic set_ch(input int ch, input logic [15:0] inc, input logic [1:0] wave,
                          input logic [3:0] att, input logic key);
        logic [31:0] word;
        logic [1:0]  resp;
        word = '0;
        word[`FM_REG_INC_LSB +: 16] = inc;
        word[`FM_REG_WAVE_LSB +: 2] = wave;
        word[`FM_REG_ATT_LSB +: 4]  = att;
        word[`FM_REG_KEY_BIT]       = key;
        axi_write(`FM_AXI_ADDR_W'(ch * 4), word, 4'hf, resp);
        check("bresp", resp, fm_pkg::OKAY);
    endtask

    // gathers n fresh frames into fl and fr
    task automatic collect(input int n);
        int waited;
        waited = 0;
        frames.delete();
        while (frames.size() < n && !hung) begin
            @(negedge clk);
            waited++;
            if (waited > n * 128 + 512) begin
                note_failure("timeout: I2S frames stopped arriving");
                hung = 1'b1;
            end
        end
        for (int i = 0; i < n; i++) begin
            fl[i] = (i < frames.size()) ? frames[i][31:16] : '0;
            fr[i] = (i < frames.size()) ? frames[i][15:0] : '0;
        end
    endtask

    task automatic clear_channels();
        for (int ch = 0; ch < `FM_NUM_CH; ch++) begin
            set_ch(ch, 16'h0, 2'd0, 4'h0, 1'b0);
        end
        collect(3);                                 // settle until every phase is back at zero
    endtask

    // keys channel 0 on and follows its phase from zero
    task automatic start_and_track(input logic [1:0] wave, input logic [3:0] att);
        logic [15:0] inc;
        logic [15:0] ph;
        int          k;
        inc = 16'($random(seed));
        set_ch(0, inc, wave, att, 1'b1);
        collect(NFR);
        k = -1;
        for (int i = NFR - 1; i >= 0; i--) begin
            if (fl[i] != 16'h0) k = i;              // first sample after key-on
        end
        if (k < 0 && !hung) begin
            note_failure("channel 0 stayed silent after key-on");
        end else if (k >= 0) begin
            ph = 16'h0;
            for (int i = k; i < NFR; i++) begin
                check("left", fl[i], ref_sample(ph, wave, att, 1'b1));
                if (i > k && att == 0 && wave == fm_pkg::WAVE_SAW) begin
                    check("left step", 16'(fl[i] - fl[i-1]), inc);
                end
                ph = ph + inc;
            end
        end
    endtask

    initial begin
        logic [31:0] data;
        logic [1:0]  resp;
        logic [3:0]  strb;
        logic [3:0]  att;
        rst_n   = 1'b0;
        awaddr  = '0;
        awvalid = 1'b0;
        wdata   = '0;
        wstrb   = '0;
        wvalid  = 1'b0;
        bready  = 1'b0;
        araddr  = '0;
        arvalid = 1'b0;
        rready  = 1'b0;
        repeat (4) @(negedge clk);
        rst_n = 1'b1;

        collect(4);                                 // nothing keyed on yet
        for (int i = 0; i < 4; i++) begin
            check("left", fl[i], 16'h0);
            check("right", fr[i], 16'h0);
        end
        finish_test("silence");

        for (int ch = 0; ch < `FM_NUM_CH; ch++) begin
            model[ch] = '0;
            for (int w = 0; w < 2; w++) begin
                data = $random(seed);
                strb = (w == 0) ? 4'hf : 4'($random(seed));    // second write partial
                axi_write(`FM_AXI_ADDR_W'(ch * 4), data, strb, resp);
                check("bresp", resp, fm_pkg::OKAY);
                for (int b = 0; b < 4; b++) begin
                    if (strb[b]) model[ch][8*b +: 8] = data[8*b +: 8];
                end
                model[ch] &= REG_MASK;
            end
        end
        axi_write(6'h10, $random(seed), 4'hf, resp);
        check("bresp", resp, fm_pkg::SLVERR);
        axi_read(6'h10, data, resp);
        check("rdata", data, 32'h0);
        check("rresp", resp, fm_pkg::SLVERR);
        for (int ch = 0; ch < `FM_NUM_CH; ch++) begin
            axi_read(`FM_AXI_ADDR_W'(ch * 4), data, resp);
            check("rdata", data, model[ch]);
            check("rresp", resp, fm_pkg::OKAY);
        end
        finish_test("readback");

        clear_channels();
        att = 4'($random(seed));
        set_ch(0, 16'h0, fm_pkg::WAVE_SQUARE, att, 1'b1);
        collect(3);
        collect(4);
        for (int i = 0; i < 4; i++) begin
            check("left", fl[i], sat_sum(ref_sample(16'h0, 2'd0, att, 1'b1), 16'h0));
            check("right", fr[i], 16'h0);
        end
        finish_test("atten");

        set_ch(0, 16'h0, fm_pkg::WAVE_SQUARE, 4'h0, 1'b1);
        set_ch(2, 16'h0, fm_pkg::WAVE_SQUARE, 4'h0, 1'b1);
        set_ch(1, 16'h0, fm_pkg::WAVE_SAW, 4'h0, 1'b1);
        set_ch(3, 16'h0, fm_pkg::WAVE_SAW, 4'h0, 1'b1);
        collect(3);
        collect(4);
        for (int i = 0; i < 4; i++) begin
            check("left", fl[i], sat_sum(ref_sample(16'h0, 2'd0, 4'h0, 1'b1),
                                         ref_sample(16'h0, 2'd0, 4'h0, 1'b1)));
            check("right", fr[i], sat_sum(ref_sample(16'h0, 2'd1, 4'h0, 1'b1),
                                          ref_sample(16'h0, 2'd1, 4'h0, 1'b1)));
        end
        finish_test("saturate");

        clear_channels();
        set_ch(1, 16'h8000, fm_pkg::WAVE_SQUARE, 4'h0, 1'b1);
        collect(3);
        collect(8);
        check("right level", (fr[0] == 16'h7fff) || (fr[0] == 16'h8000), 1'b1);
        for (int i = 1; i < 8; i++) begin
            check("right", fr[i], (fr[i-1] == 16'h7fff) ? 16'h8000 : 16'h7fff);
        end
        finish_test("square");

        clear_channels();
        start_and_track(fm_pkg::WAVE_SAW, 4'h0);
        finish_test("sawtooth");

        set_ch(0, 16'h0, 2'd0, 4'h0, 1'b0);
        collect(3);
        start_and_track(fm_pkg::WAVE_TRI, 4'h0);
        finish_test("triangle");

        set_ch(0, 16'h1234, fm_pkg::WAVE_TRI, 4'h0, 1'b0);   // key off with other fields kept
        collect(3);
        collect(4);
        for (int i = 0; i < 4; i++) begin
            check("left", fl[i], 16'h0);
        end
        start_and_track(fm_pkg::WAVE_SAW, 4'($random(seed)));
        finish_test("key_off");

        if (dut.u_assert.fails != 0) begin
            $display("%0d protocol assertions failed", dut.u_assert.fails);
            errors += dut.u_assert.fails;
        end
        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire
